/* source/loopback_config.svh */
/*
 * build parameters of the copy accelerator
 * widths of addresses, sizes and line indices, memory depth,
 * and the MMIO register map
 */
`ifndef LOOPBACK_CONFIG_SVH
`define LOOPBACK_CONFIG_SVH

// ====================
// widths and depth
// ====================

// read and write byte addresses are one full 64-bit MMIO word
`define LB_ADDR_WIDTH 64
// the size register counts lines, not bytes
`define LB_SIZE_WIDTH 16
// a line index addresses one of LB_MEM_DEPTH lines
`define LB_INDEX_WIDTH 8
`define LB_MEM_DEPTH 256

// ====================
// MMIO register map
// ====================

// addresses stay even as CCI-P requires for 64-bit data
`define LB_REG_GO      16'h0050
`define LB_REG_RD_ADDR 16'h0052
`define LB_REG_WR_ADDR 16'h0054
`define LB_REG_SIZE    16'h0056
`define LB_REG_DONE    16'h0058
`define LB_REG_INDEX   16'h0060
`define LB_REG_WDATA   16'h0062
`define LB_REG_RDATA   16'h0064

`endif

/* source/loopback_pkg.sv */
/*
 * shared types of the copy accelerator
 * line word, DMA command and the two memory request structs
 */
`include "loopback_config.svh"

package loopback_pkg;

   // one memory line, which is also one MMIO data word
   typedef logic [63:0] line_t;

   // a copy command as software programs it through the register file
   typedef struct packed {
      logic [`LB_ADDR_WIDTH-1:0] rd_addr;
      logic [`LB_ADDR_WIDTH-1:0] wr_addr;
      logic [`LB_SIZE_WIDTH-1:0] size;
   } dma_cmd_t;

   // one read request on the memory read port
   typedef struct packed {
      logic                       en;
      logic [`LB_INDEX_WIDTH-1:0] index;
   } mem_rd_t;

   // one write request on the memory write port
   typedef struct packed {
      logic                       en;
      logic [`LB_INDEX_WIDTH-1:0] index;
      line_t                      data;
   } mem_wr_t;

endpackage

/* source/mmio_if.sv */
/*
 * MMIO bus interface with single-cycle reads
 * user modport for the accelerator, host modport for software side
 */
`timescale 1ns/1ps

interface mmio_if;

   // strobes, each valid for exactly one cycle per access
   logic        rd_en;
   logic        wr_en;

   // word addresses, even for every 64-bit register
   logic [15:0] rd_addr;
   logic [15:0] wr_addr;

   logic [63:0] wr_data;
   // returned on the clock edge after rd_en
   logic [63:0] rd_data;

   // the accelerator side samples requests and returns read data
   modport user (
      input  rd_en, wr_en, rd_addr, wr_addr, wr_data,
      output rd_data
   );

   // the software side issues requests and samples read data
   modport host (
      output rd_en, wr_en, rd_addr, wr_addr, wr_data,
      input  rd_data
   );

endinterface

/* source/line_memory.sv */
/*
 * line RAM of the copy accelerator
 * one synchronous read port and one write port
 */
`timescale 1ns/1ps
`include "loopback_config.svh"

module line_memory (
   input  logic                  clk,
   input  loopback_pkg::mem_rd_t rd_req,
   input  loopback_pkg::mem_wr_t wr_req,
   output loopback_pkg::line_t   rd_line
);
   import loopback_pkg::*;

   // storage array, LB_MEM_DEPTH lines of one word each
   line_t mem [`LB_MEM_DEPTH];

   // ====================
   // write port
   // ====================

   always_ff @(posedge clk) begin
      if (wr_req.en) begin
         mem[wr_req.index] <= wr_req.data;
      end
   end

   // ====================
   // read port
   // ====================

   // the line appears one cycle after the request and holds until the next one
   // a read and a write of the same line in one cycle return the old contents
   always_ff @(posedge clk) begin
      if (rd_req.en) begin
         rd_line <= mem[rd_req.index];
      end
   end

endmodule

/* source/dma_engine.sv */
/*
 * copy engine of the accelerator
 * read and write index generation, line count and done flag
 */
`timescale 1ns/1ps
`include "loopback_config.svh"

module dma_engine (
   input  logic                   clk,
   input  logic                   rst,
   input  loopback_pkg::dma_cmd_t cmd,
   input  logic                   go,
   input  loopback_pkg::line_t    rd_line,
   output loopback_pkg::mem_rd_t  dma_rd,
   output loopback_pkg::mem_wr_t  dma_wr,
   output logic                   busy,
   output logic                   done
);

   // next source and destination line of the copy
   logic [`LB_INDEX_WIDTH-1:0] rd_index;
   logic [`LB_INDEX_WIDTH-1:0] wr_index;
   // destination of the line the memory returns this cycle
   logic [`LB_INDEX_WIDTH-1:0] wr_index_d;
   // reads still to issue
   logic [`LB_SIZE_WIDTH-1:0]  rd_left;
   // lines already written and the length of the copy
   logic [`LB_SIZE_WIDTH-1:0]  wr_count;
   logic [`LB_SIZE_WIDTH-1:0]  size_q;
   // a read was issued last cycle, so rd_line holds a line to write
   logic                       rd_valid_d;
   logic                       start;
   logic                       last_wr;

   // a go while a copy is running has no effect
   assign start = go && !busy;

   assign last_wr = rd_valid_d && (wr_count == size_q - 1'b1);

   // ====================
   // memory requests
   // ====================

   // reads run on cycles 1 to N after go, each write trails its read by one
   always_comb begin
      dma_rd.en    = busy && (rd_left != '0);
      dma_rd.index = rd_index;
      dma_wr.en    = rd_valid_d;
      dma_wr.index = wr_index_d;
      dma_wr.data  = rd_line;
   end

   // ====================
   // control
   // ====================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_index   <= '0;
         wr_index   <= '0;
         wr_index_d <= '0;
         rd_left    <= '0;
         wr_count   <= '0;
         size_q     <= '0;
         rd_valid_d <= 1'b0;
         busy       <= 1'b0;
         done       <= 1'b0;
      end else begin
         rd_valid_d <= dma_rd.en;
         if (dma_rd.en) begin
            wr_index_d <= wr_index;
            rd_index   <= rd_index + 1'b1;
            wr_index   <= wr_index + 1'b1;
            rd_left    <= rd_left - 1'b1;
         end
         if (dma_wr.en) begin
            wr_count <= wr_count + 1'b1;
         end
         if (start) begin
            // byte addresses become line indices that wrap with the memory depth
            rd_index <= cmd.rd_addr[3 +: `LB_INDEX_WIDTH];
            wr_index <= cmd.wr_addr[3 +: `LB_INDEX_WIDTH];
            rd_left  <= cmd.size;
            size_q   <= cmd.size;
            wr_count <= '0;
            // an empty copy finishes at once and never becomes busy
            busy     <= (cmd.size != '0);
            done     <= (cmd.size == '0);
         end else if (last_wr) begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

endmodule

/* source/memory_map.sv */
/*
 * MMIO register file of the copy accelerator
 * command registers, go pulse, done readback and the
 * auto-incrementing data window onto the line memory
 */
`timescale 1ns/1ps
`include "loopback_config.svh"

module memory_map (
   input  logic                   clk,
   input  logic                   rst,
   mmio_if.user                   mmio,
   input  logic                   done,
   input  logic                   busy,
   input  loopback_pkg::line_t    rd_line,
   output loopback_pkg::dma_cmd_t cmd,
   output logic                   go,
   output loopback_pkg::mem_rd_t  host_rd,
   output loopback_pkg::mem_wr_t  host_wr
);
   import loopback_pkg::*;

   // line index the data window currently points at
   logic [`LB_INDEX_WIDTH-1:0] win_index;
   // line fetched ahead so that a window read completes in one cycle
   line_t                      prefetch;
   // high in the cycle where the memory presents a line for the window
   logic                       prefetch_pend;
   line_t                      window_line;
   logic                       index_wr;
   logic                       wdata_wr;
   logic                       rdata_rd;

   // ====================
   // data window decode
   // ====================

   assign index_wr = mmio.wr_en && (mmio.wr_addr == `LB_REG_INDEX);
   assign wdata_wr = mmio.wr_en && (mmio.wr_addr == `LB_REG_WDATA);
   assign rdata_rd = mmio.rd_en && (mmio.rd_addr == `LB_REG_RDATA);

   // a fresh index fetches that line, a window read fetches the next one
   always_comb begin
      host_rd.en    = index_wr || rdata_rd;
      host_rd.index = index_wr ? mmio.wr_data[`LB_INDEX_WIDTH-1:0] : win_index + 1'b1;
      host_wr.en    = wdata_wr;
      host_wr.index = win_index;
      host_wr.data  = mmio.wr_data;
   end

   // the line still on the memory output is newer than the held copy,
   // so back-to-back window reads take it directly
   assign window_line = prefetch_pend ? rd_line : prefetch;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         win_index     <= '0;
         prefetch_pend <= 1'b0;
         prefetch      <= '0;
      end else begin
         // while the DMA runs it owns the read port and the host fetch is lost
         prefetch_pend <= host_rd.en && !busy;
         if (prefetch_pend) begin
            prefetch <= rd_line;
         end
         if (index_wr) begin
            win_index <= mmio.wr_data[`LB_INDEX_WIDTH-1:0];
         end else if (wdata_wr || rdata_rd) begin
            win_index <= win_index + 1'b1;
         end
      end
   end

   // ====================
   // MMIO writes
   // ====================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         go  <= 1'b0;
         cmd <= '0;
      end else begin
         // go is a pulse and drops again unless rewritten
         go <= 1'b0;
         if (mmio.wr_en) begin
            case (mmio.wr_addr)
               `LB_REG_GO:      go          <= mmio.wr_data[0];
               `LB_REG_RD_ADDR: cmd.rd_addr <= mmio.wr_data[`LB_ADDR_WIDTH-1:0];
               `LB_REG_WR_ADDR: cmd.wr_addr <= mmio.wr_data[`LB_ADDR_WIDTH-1:0];
               `LB_REG_SIZE:    cmd.size    <= mmio.wr_data[`LB_SIZE_WIDTH-1:0];
               default: ;
            endcase
         end
      end
   end

   // ====================
   // MMIO reads
   // ====================

   // every read is answered on the next edge, unused addresses give zero
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mmio.rd_data <= '0;
      end else if (mmio.rd_en) begin
         mmio.rd_data <= '0;
         case (mmio.rd_addr)
            `LB_REG_RD_ADDR: mmio.rd_data[`LB_ADDR_WIDTH-1:0]  <= cmd.rd_addr;
            `LB_REG_WR_ADDR: mmio.rd_data[`LB_ADDR_WIDTH-1:0]  <= cmd.wr_addr;
            `LB_REG_SIZE:    mmio.rd_data[`LB_SIZE_WIDTH-1:0]  <= cmd.size;
            `LB_REG_DONE:    mmio.rd_data[0]                   <= done;
            `LB_REG_INDEX:   mmio.rd_data[`LB_INDEX_WIDTH-1:0] <= win_index;
            `LB_REG_RDATA:   mmio.rd_data                      <= window_line;
            default: ;
         endcase
      end
   end

endmodule

/* source/loopback_afu.sv */
/*
 * top level of the copy accelerator
 * register file, copy engine, line memory and the port arbiters
 */
`timescale 1ns/1ps

module loopback_afu (
   input logic  clk,
   input logic  rst,
   mmio_if.user mmio
);
   import loopback_pkg::*;

   dma_cmd_t cmd;
   logic     go;
   logic     busy;
   logic     done;
   // requests from both masters and the ones that reach the memory
   mem_rd_t  host_rd;
   mem_rd_t  dma_rd;
   mem_rd_t  mem_rd;
   mem_wr_t  host_wr;
   mem_wr_t  dma_wr;
   mem_wr_t  mem_wr;
   line_t    rd_line;

   // the copy engine has priority on both ports and a losing host request is dropped
   assign mem_rd = dma_rd.en ? dma_rd : host_rd;
   assign mem_wr = dma_wr.en ? dma_wr : host_wr;

   memory_map u_memory_map (
      .clk     (clk),
      .rst     (rst),
      .mmio    (mmio),
      .done    (done),
      .busy    (busy),
      .rd_line (rd_line),
      .cmd     (cmd),
      .go      (go),
      .host_rd (host_rd),
      .host_wr (host_wr)
   );

   dma_engine u_dma_engine (
      .clk     (clk),
      .rst     (rst),
      .cmd     (cmd),
      .go      (go),
      .rd_line (rd_line),
      .dma_rd  (dma_rd),
      .dma_wr  (dma_wr),
      .busy    (busy),
      .done    (done)
   );

   // the one read port serves the window prefetch and the copy engine
   line_memory u_line_memory (
      .clk     (clk),
      .rd_req  (mem_rd),
      .wr_req  (mem_wr),
      .rd_line (rd_line)
   );

endmodule

/* test/loopback_afu_properties.sv */
/*
 * protocol assertions of the copy accelerator
 * go pulse, done clearing, read to write pairing, port ownership
 */
`timescale 1ns/1ps

module loopback_afu_properties (
   input logic                  clk,
   input logic                  rst,
   input logic                  go,
   input logic                  busy,
   input logic                  done,
   input loopback_pkg::mem_rd_t dma_rd,
   input loopback_pkg::mem_rd_t mem_rd,
   input loopback_pkg::mem_wr_t dma_wr,
   input loopback_pkg::mem_wr_t mem_wr
);

   // go is a one-cycle pulse
   go_pulse: assert property (@(posedge clk) disable iff (rst) go |=> !go)
      else $error("go stayed high for more than one cycle");

   // only a new copy may clear done
   done_clear: assert property (@(posedge clk) disable iff (rst) $fell(done) |-> $past(go))
      else $error("done fell without a go in the cycle before");

   // every line the engine reads is written one cycle later,
   // to the line after the one written in the cycle before
   rd_then_wr: assert property (@(posedge clk) disable iff (rst)
                                dma_rd.en |=> dma_wr.en &&
                                (!$past(dma_wr.en) ||
                                 dma_wr.index == $past(dma_wr.index) + 1'b1))
      else $error("a DMA read was not followed by a write to the next destination line");

   // while a copy runs the host reaches neither memory port
   busy_rd_port: assert property (@(posedge clk) disable iff (rst)
                                  busy |-> (mem_rd.en == dma_rd.en))
      else $error("a host read reached the memory while busy");
   busy_wr_port: assert property (@(posedge clk) disable iff (rst)
                                  busy |-> (mem_wr.en == dma_wr.en))
      else $error("a host write reached the memory while busy");

endmodule

bind loopback_afu loopback_afu_properties u_properties (
   .clk    (clk),
   .rst    (rst),
   .go     (go),
   .busy   (busy),
   .done   (done),
   .dma_rd (dma_rd),
   .mem_rd (mem_rd),
   .dma_wr (dma_wr),
   .mem_wr (mem_wr)
);

/* test/loopback_afu_tb.sv */
/*
 * testbench of the copy accelerator
 * clock and reset, MMIO host tasks, random lines and copies,
 * a shadow model of the line memory and the closing report
 */
`timescale 1ns/1ps
`include "loopback_config.svh"

module loopback_afu_tb;
   import loopback_pkg::*;

   logic        clk;
   logic        rst;
   mmio_if      bus ();
   // what the line memory should hold after every host write and copy
   line_t       shadow [`LB_MEM_DEPTH];
   logic [31:0] lcg_state;
   int          mismatches;
   int          timeouts;

   loopback_afu UUT (.clk(clk), .rst(rst), .mmio(bus));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ====================
   // random numbers
   // ====================

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [63:0] random_word();
      logic [31:0] hi;
      hi = next_random();
      return {hi, next_random()};
   endfunction

   // ====================
   // MMIO host
   // ====================

   // every task starts and ends on a falling edge
   task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
      bus.wr_en   = 1'b1;
      bus.wr_addr = addr;
      bus.wr_data = data;
      @(negedge clk);
      bus.wr_en   = 1'b0;
   endtask

   // read data is registered on the rising edge inside the access cycle
   task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
      bus.rd_en   = 1'b1;
      bus.rd_addr = addr;
      @(negedge clk);
      bus.rd_en   = 1'b0;
      data        = bus.rd_data;
   endtask

   task automatic compare_word(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
      assert (actual === expected)
      else begin
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic check_read(input string name, input logic [15:0] addr,
                             input logic [63:0] expected);
      logic [63:0] word;
      mmio_read(addr, word);
      compare_word(name, expected, word);
   endtask

   // polls the done register, each poll is one MMIO read
   task automatic wait_done(input string name);
      logic [63:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (status[0] !== 1'b1 && polls < 200) begin
         mmio_read(`LB_REG_DONE, status);
         polls++;
      end
      if (status[0] !== 1'b1) begin
         $display("timeout in %s: done never rose after go", name);
         timeouts++;
      end
   endtask

   // ====================
   // memory and copies
   // ====================

   task automatic fill_memory(input logic [7:0] start);
      line_t value;
      int    i;
      mmio_write(`LB_REG_INDEX, {56'd0, start});
      for (i = 0; i < `LB_MEM_DEPTH; i++) begin
         value = random_word();
         shadow[8'(start + i)] = value;
         mmio_write(`LB_REG_WDATA, value);
      end
   endtask

   // the window wraps, so a read from line 0 covers the whole memory
   task automatic check_memory(input string name);
      logic [63:0] word;
      int          i;
      mmio_write(`LB_REG_INDEX, 64'd0);
      for (i = 0; i < `LB_MEM_DEPTH; i++) begin
         mmio_read(`LB_REG_RDATA, word);
         compare_word(name, shadow[8'(i)], word);
      end
   endtask

   // the destination starts at least n lines past the source and ends
   // at least n lines before it, so the two regions never overlap
   task automatic run_copy(input string name, input int n);
      logic [63:0] pick;
      logic [63:0] noise;
      logic [7:0]  src;
      logic [7:0]  dst;
      int          i;
      pick  = random_word();
      src   = pick[7:0];
      dst   = 8'(src + n + (pick[31:16] % (`LB_MEM_DEPTH - 2 * n + 1)));
      // bits around the line index carry noise the engine must drop
      noise = random_word();
      mmio_write(`LB_REG_RD_ADDR, {noise[63:11], src, noise[2:0]});
      noise = random_word();
      mmio_write(`LB_REG_WR_ADDR, {noise[63:11], dst, noise[2:0]});
      mmio_write(`LB_REG_SIZE, 64'(n));
      mmio_write(`LB_REG_GO, 64'd1);
      // the engine takes go one cycle after the register write
      @(negedge clk);
      if (n > 0) begin
         check_read({name, " done clear"}, `LB_REG_DONE, 64'd0);
      end
      for (i = 0; i < n; i++) begin
         shadow[8'(dst + i)] = shadow[8'(src + i)];
      end
      wait_done(name);
      check_memory(name);
   endtask

   // ====================
   // stimulus
   // ====================

   initial begin
      logic [63:0] word;
      int          n;
      int          k;
      lcg_state   = 32'h1bc9_7e17;
      mismatches  = 0;
      timeouts    = 0;
      rst         = 1'b1;
      bus.rd_en   = 1'b0;
      bus.wr_en   = 1'b0;
      bus.rd_addr = '0;
      bus.wr_addr = '0;
      bus.wr_data = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      check_read("reset done", `LB_REG_DONE, 64'd0);
      check_read("reset rd_addr", `LB_REG_RD_ADDR, 64'd0);
      check_read("reset wr_addr", `LB_REG_WR_ADDR, 64'd0);
      check_read("reset size", `LB_REG_SIZE, 64'd0);
      check_read("unused address", 16'h0066, 64'd0);

      // command registers keep only as many bits as they are wide
      word = random_word();
      mmio_write(`LB_REG_RD_ADDR, word);
      check_read("rd_addr readback", `LB_REG_RD_ADDR, word);
      word = random_word();
      mmio_write(`LB_REG_WR_ADDR, word);
      check_read("wr_addr readback", `LB_REG_WR_ADDR, word);
      word = random_word();
      mmio_write(`LB_REG_SIZE, word);
      check_read("size readback", `LB_REG_SIZE,
                 word & ((64'd1 << `LB_SIZE_WIDTH) - 64'd1));

      word = random_word();
      fill_memory(word[7:0]);
      check_memory("window");

      // done is still low from reset, so the empty copy must raise it itself
      run_copy("zero copy", 0);
      run_copy("copy", 16);
      run_copy("second copy", 8);
      for (k = 0; k < 6; k++) begin
         word = random_word();
         n    = 1 + int'(word[4:0]);
         run_copy("random copy", n);
      end

      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* loopback_afu.f */
+incdir+source
source/loopback_pkg.sv
source/mmio_if.sv
source/line_memory.sv
source/dma_engine.sv
source/memory_map.sv
source/loopback_afu.sv
test/loopback_afu_properties.sv
test/loopback_afu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the loopback_afu testbench with Verilator, runs it and checks the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f loopback_afu.f --top-module loopback_afu_tb -o sim_loopback_afu

./obj_dir/sim_loopback_afu | tee sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
